//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- common/mips_id_pkg.sv
`default_nettype none

package mips_id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // one-hot, add in the top bit down to lui in bit 0
    typedef logic [11:0] alu_op_t;

    // bit 0 rs, bit 1 pc, bit 2 shamt
    typedef logic [2:0] src1_sel_t;

    // bit 0 rt, bit 1 sign-extended imm, bit 2 constant 8, bit 3 zero-extended imm
    typedef logic [3:0] src2_sel_t;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bltz,
        br_bgtz,
        br_blez,
        br_jabs,
        br_jreg
    } br_class_e;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [15:0]           imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_word_u;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_sub  = 6'h22;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // rt field codes under op_regimm
    localparam logic [reg_addr_w-1:0] rt_bltz   = 5'h00;
    localparam logic [reg_addr_w-1:0] rt_bgez   = 5'h01;
    localparam logic [reg_addr_w-1:0] rt_bltzal = 5'h10;
    localparam logic [reg_addr_w-1:0] rt_bgezal = 5'h11;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

endpackage

`default_nettype wire

//--- decode/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
    input  mips_id_pkg::instr_word_u           inst_i,
    input  logic                               valid_i,
    input  logic                               ex_is_load_i,
    input  logic [mips_id_pkg::reg_addr_w-1:0] ex_waddr_i,
    output mips_id_pkg::alu_op_t               alu_op_o,
    output mips_id_pkg::src1_sel_t             src1_sel_o,
    output mips_id_pkg::src2_sel_t             src2_sel_o,
    output logic                               mem_en_o,
    output logic                               mem_we_o,
    output logic                               rf_we_o,
    output logic [mips_id_pkg::reg_addr_w-1:0] rf_waddr_o,
    output logic                               rf_res_sel_o,
    output mips_id_pkg::br_class_e             br_class_o,
    output logic                               stall_req_o
);

    import mips_id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       is_special;
    logic       r_plain;

    logic inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_bgtz, inst_blez;
    logic inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr;

    logic r_arith, shift_imm, shift_var, imm_sext, imm_zext, link, mem_op;
    logic dst_rd, dst_rt, dst_31;

    assign opcode     = inst_i.r.opcode;
    assign funct      = inst_i.r.funct;
    assign is_special = (opcode == op_special);
    // register forms with a zero shamt field
    assign r_plain    = is_special && (inst_i.r.shamt == '0);

    assign inst_add  = r_plain && (funct == fn_add);
    assign inst_addu = r_plain && (funct == fn_addu);
    assign inst_sub  = r_plain && (funct == fn_sub);
    assign inst_subu = r_plain && (funct == fn_subu);
    assign inst_slt  = r_plain && (funct == fn_slt);
    assign inst_sltu = r_plain && (funct == fn_sltu);
    assign inst_and  = r_plain && (funct == fn_and);
    assign inst_or   = r_plain && (funct == fn_or);
    assign inst_xor  = r_plain && (funct == fn_xor);
    assign inst_nor  = r_plain && (funct == fn_nor);
    assign inst_sll  = is_special && (inst_i.r.rs == '0) && (funct == fn_sll);
    assign inst_srl  = is_special && (inst_i.r.rs == '0) && (funct == fn_srl);
    assign inst_sra  = is_special && (inst_i.r.rs == '0) && (funct == fn_sra);
    assign inst_sllv = r_plain && (funct == fn_sllv);
    assign inst_srlv = r_plain && (funct == fn_srlv);
    assign inst_srav = r_plain && (funct == fn_srav);
    assign inst_jr   = r_plain && (inst_i.r.rt == '0) && (inst_i.r.rd == '0) && (funct == fn_jr);
    assign inst_jalr = r_plain && (inst_i.r.rt == '0) && (funct == fn_jalr);

    assign inst_addi   = (opcode == op_addi);
    assign inst_addiu  = (opcode == op_addiu);
    assign inst_slti   = (opcode == op_slti);
    assign inst_sltiu  = (opcode == op_sltiu);
    assign inst_andi   = (opcode == op_andi);
    assign inst_ori    = (opcode == op_ori);
    assign inst_xori   = (opcode == op_xori);
    assign inst_lui    = (opcode == op_lui) && (inst_i.i.rs == '0);
    assign inst_lw     = (opcode == op_lw);
    assign inst_sw     = (opcode == op_sw);
    assign inst_beq    = (opcode == op_beq);
    assign inst_bne    = (opcode == op_bne);
    assign inst_bgtz   = (opcode == op_bgtz) && (inst_i.i.rt == '0);
    assign inst_blez   = (opcode == op_blez) && (inst_i.i.rt == '0);
    assign inst_bgez   = (opcode == op_regimm) && (inst_i.i.rt == rt_bgez);
    assign inst_bltz   = (opcode == op_regimm) && (inst_i.i.rt == rt_bltz);
    assign inst_bgezal = (opcode == op_regimm) && (inst_i.i.rt == rt_bgezal);
    assign inst_bltzal = (opcode == op_regimm) && (inst_i.i.rt == rt_bltzal);
    assign inst_j      = (opcode == op_j);
    assign inst_jal    = (opcode == op_jal);

    assign r_arith   = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                     | inst_and | inst_or | inst_xor | inst_nor;
    assign shift_imm = inst_sll | inst_srl | inst_sra;
    assign shift_var = inst_sllv | inst_srlv | inst_srav;
    assign imm_sext  = inst_addi | inst_addiu | inst_slti | inst_sltiu;
    assign imm_zext  = inst_andi | inst_ori | inst_xori;
    // return address is pc + 8, built in the ALU
    assign link      = inst_jal | inst_bgezal | inst_bltzal | inst_jalr;
    assign mem_op    = inst_lw | inst_sw;

    assign src1_sel_o = {shift_imm, link, r_arith | shift_var | imm_sext | imm_zext | mem_op};
    assign src2_sel_o = {imm_zext, link, inst_lui | imm_sext | mem_op,
                         r_arith | shift_imm | shift_var};

    assign alu_op_o = {inst_add | inst_addu | inst_addi | inst_addiu | mem_op | link,
                       inst_sub | inst_subu,
                       inst_slt | inst_slti,
                       inst_sltu | inst_sltiu,
                       inst_and | inst_andi,
                       inst_nor,
                       inst_or | inst_ori,
                       inst_xor | inst_xori,
                       inst_sll | inst_sllv,
                       inst_srl | inst_srlv,
                       inst_sra | inst_srav,
                       inst_lui};

    assign mem_en_o     = valid_i && mem_op;
    assign mem_we_o     = valid_i && inst_sw;
    assign rf_res_sel_o = inst_lw;

    assign dst_rd  = r_arith | shift_imm | shift_var | inst_jalr;
    assign dst_rt  = imm_sext | imm_zext | inst_lui | inst_lw;
    assign dst_31  = inst_jal | inst_bgezal | inst_bltzal;
    assign rf_we_o = valid_i && (dst_rd | dst_rt | dst_31);

    assign rf_waddr_o = dst_rd ? inst_i.r.rd :
                        dst_rt ? inst_i.i.rt :
                        dst_31 ? link_reg    : '0;

    always_comb begin
        if (inst_beq)                    br_class_o = br_beq;
        else if (inst_bne)               br_class_o = br_bne;
        else if (inst_bgez | inst_bgezal) br_class_o = br_bgez;
        else if (inst_bltz | inst_bltzal) br_class_o = br_bltz;
        else if (inst_bgtz)              br_class_o = br_bgtz;
        else if (inst_blez)              br_class_o = br_blez;
        else if (inst_j | inst_jal)      br_class_o = br_jabs;
        else if (inst_jr | inst_jalr)    br_class_o = br_jreg;
        else                             br_class_o = br_none;
    end

    // load in execute still owes a source register
    assign stall_req_o = valid_i && ex_is_load_i && (ex_waddr_i != '0)
                      && ((ex_waddr_i == inst_i.i.rs) || (ex_waddr_i == inst_i.i.rt));

endmodule

`default_nettype wire

//--- design/id_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit (
    input  logic [mips_id_pkg::xlen-1:0] pc_i,
    input  mips_id_pkg::instr_word_u     inst_i,
    input  logic                         valid_i,
    input  mips_id_pkg::br_class_e       br_class_i,
    input  logic [mips_id_pkg::xlen-1:0] rs_val_i,
    input  logic [mips_id_pkg::xlen-1:0] rt_val_i,
    output logic                         br_taken_o,
    output logic [mips_id_pkg::xlen-1:0] br_target_o
);

    import mips_id_pkg::*;

    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] br_offset;
    logic            rs_zero;
    logic            rs_neg;
    logic            cond;

    assign pc_plus_4 = pc_i + xlen'(4);
    // word offset, sign-extended
    assign br_offset = {{(xlen-18){inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
    assign rs_zero   = (rs_val_i == '0);
    assign rs_neg    = rs_val_i[xlen-1];

    always_comb begin
        cond        = 1'b0;
        br_target_o = pc_plus_4 + br_offset;
        case (br_class_i)
            br_beq:  cond = (rs_val_i == rt_val_i);
            br_bne:  cond = (rs_val_i != rt_val_i);
            br_bgez: cond = !rs_neg;
            br_bltz: cond = rs_neg;
            br_bgtz: cond = !rs_neg && !rs_zero;
            br_blez: cond = rs_neg || rs_zero;
            br_jabs: begin
                cond        = 1'b1;
                // stays inside the current 256 MB region
                br_target_o = {pc_plus_4[xlen-1:xlen-4], inst_i.j.target, 2'b00};
            end
            br_jreg: begin
                cond        = 1'b1;
                br_target_o = rs_val_i;
            end
            default: begin
                cond        = 1'b0;
                br_target_o = '0;
            end
        endcase
    end

    assign br_taken_o = valid_i && cond;

endmodule

`default_nettype wire

//--- design/id_input_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_input_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [mips_id_pkg::xlen-1:0] if_pc_i,
    input  logic                         if_valid_i,
    input  logic                         id_stall_i,
    input  logic                         ex_stall_i,
    input  logic [mips_id_pkg::xlen-1:0] inst_rdata_i,
    output logic [mips_id_pkg::xlen-1:0] pc_o,
    output logic                         valid_o,
    output mips_id_pkg::instr_word_u     inst_o
);

    import mips_id_pkg::*;

    instr_word_u hold_inst_q;
    logic        hold_en_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o    <= '0;
            valid_o <= 1'b0;
        end else if (id_stall_i && !ex_stall_i) begin
            // execute moves on, so send it a bubble
            pc_o    <= '0;
            valid_o <= 1'b0;
        end else if (!id_stall_i) begin
            pc_o    <= if_pc_i;
            valid_o <= if_valid_i;
        end
    end

    // memory data moves on during a stall, keep our own copy
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_en_q <= 1'b0;
        end else begin
            hold_en_q <= id_stall_i;
        end
    end

    always_ff @(posedge clk) begin
        if (id_stall_i) begin
            hold_inst_q <= inst_o;
        end
    end

    assign inst_o = hold_en_q ? hold_inst_q : inst_rdata_i;

endmodule

`default_nettype wire

//--- design/id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module id_regfile (
    input  logic                               clk,
    input  logic [mips_id_pkg::reg_addr_w-1:0] raddr1_i,
    input  logic [mips_id_pkg::reg_addr_w-1:0] raddr2_i,
    input  logic                               we_i,
    input  logic [mips_id_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [mips_id_pkg::xlen-1:0]       wdata_i,
    output logic [mips_id_pkg::xlen-1:0]       rdata1_o,
    output logic [mips_id_pkg::xlen-1:0]       rdata2_o
);

    import mips_id_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];
    logic            wr_en;

    // r0 is never written
    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle writeback bypasses the array
    assign rdata1_o = (raddr1_i == '0)                  ? '0      :
                      (wr_en && (waddr_i == raddr1_i)) ? wdata_i :
                                                          regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                  ? '0      :
                      (wr_en && (waddr_i == raddr2_i)) ? wdata_i :
                                                          regs[raddr2_i];

endmodule

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [mips_id_pkg::xlen-1:0]       if_pc_i,
    input  logic                               if_valid_i,
    input  logic                               id_stall_i,
    input  logic                               ex_stall_i,
    input  logic [mips_id_pkg::xlen-1:0]       inst_rdata_i,
    input  logic                               wb_we_i,
    input  logic [mips_id_pkg::reg_addr_w-1:0] wb_waddr_i,
    input  logic [mips_id_pkg::xlen-1:0]       wb_wdata_i,
    input  logic                               ex_is_load_i,
    input  logic [mips_id_pkg::reg_addr_w-1:0] ex_waddr_i,
    output logic [mips_id_pkg::xlen-1:0]       id_pc_o,
    output mips_id_pkg::instr_word_u           id_inst_o,
    output logic                               id_valid_o,
    output mips_id_pkg::alu_op_t               alu_op_o,
    output mips_id_pkg::src1_sel_t             src1_sel_o,
    output mips_id_pkg::src2_sel_t             src2_sel_o,
    output logic                               mem_en_o,
    output logic                               mem_we_o,
    output logic                               rf_we_o,
    output logic [mips_id_pkg::reg_addr_w-1:0] rf_waddr_o,
    output logic                               rf_res_sel_o,
    output logic [mips_id_pkg::xlen-1:0]       rdata1_o,
    output logic [mips_id_pkg::xlen-1:0]       rdata2_o,
    output logic                               br_taken_o,
    output logic [mips_id_pkg::xlen-1:0]       br_target_o,
    output logic                               stall_req_o
);

    import mips_id_pkg::*;

    br_class_e br_class;

    id_input_reg u_input_reg (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .if_valid_i   (if_valid_i),
        .id_stall_i   (id_stall_i),
        .ex_stall_i   (ex_stall_i),
        .inst_rdata_i (inst_rdata_i),
        .pc_o         (id_pc_o),
        .valid_o      (id_valid_o),
        .inst_o       (id_inst_o)
    );

    // decoder and register file both look at the same word
    id_decoder u_decoder (
        .inst_i       (id_inst_o),
        .valid_i      (id_valid_o),
        .ex_is_load_i (ex_is_load_i),
        .ex_waddr_i   (ex_waddr_i),
        .alu_op_o     (alu_op_o),
        .src1_sel_o   (src1_sel_o),
        .src2_sel_o   (src2_sel_o),
        .mem_en_o     (mem_en_o),
        .mem_we_o     (mem_we_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .rf_res_sel_o (rf_res_sel_o),
        .br_class_o   (br_class),
        .stall_req_o  (stall_req_o)
    );

    id_regfile u_regfile (
        .clk      (clk),
        .raddr1_i (id_inst_o.i.rs),
        .raddr2_i (id_inst_o.i.rt),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .rdata1_o (rdata1_o),
        .rdata2_o (rdata2_o)
    );

    id_branch_unit u_branch_unit (
        .pc_i        (id_pc_o),
        .inst_i      (id_inst_o),
        .valid_i     (id_valid_o),
        .br_class_i  (br_class),
        .rs_val_i    (rdata1_o),
        .rt_val_i    (rdata2_o),
        .br_taken_o  (br_taken_o),
        .br_target_o (br_target_o)
    );

endmodule

`default_nettype wire

//--- testbench/id_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_properties (
    input logic        clk,
    input logic        rst,
    input logic [11:0] alu_op_i,
    input logic        mem_en_i,
    input logic        mem_we_i,
    input logic        rf_we_i,
    input logic        br_taken_i,
    input logic        stall_req_i,
    input logic        valid_i
);

    store_needs_enable: assert property (@(posedge clk) disable iff (rst) mem_we_i |-> mem_en_i)
        else $error("mem_we_o without mem_en_o");

    alu_op_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(alu_op_i))
        else $error("alu_op_o has more than one bit set");

    taken_needs_valid: assert property (@(posedge clk) disable iff (rst) br_taken_i |-> valid_i)
        else $error("br_taken_o while decode is empty");

    // valid was cleared by the reset edge
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !(rf_we_i || mem_en_i || mem_we_i || br_taken_i || stall_req_i))
        else $error("control outputs high after reset");

endmodule

bind id_stage id_stage_properties u_properties (
    .clk         (clk),
    .rst         (rst),
    .alu_op_i    (alu_op_o),
    .mem_en_i    (mem_en_o),
    .mem_we_i    (mem_we_o),
    .rf_we_i     (rf_we_o),
    .br_taken_i  (br_taken_o),
    .stall_req_i (stall_req_o),
    .valid_i     (id_valid_o)
);

`default_nettype wire

//--- testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    import mips_id_pkg::*;

    typedef struct packed {
        logic [11:0] alu;
        logic [2:0]  s1;
        logic [3:0]  s2;
        logic        mem_en;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  waddr;
        logic        res_sel;
        logic        taken;
        logic [31:0] target;
    } exp_t;

    localparam logic [5:0] r_fns [16] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
        fn_and, fn_or, fn_xor, fn_nor, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
    localparam logic [5:0] i_ops [8] = '{op_addi, op_addiu, op_slti, op_sltiu,
        op_andi, op_ori, op_xori, op_lui};

    logic clk, rst, if_valid_i, id_stall_i, ex_stall_i, wb_we_i, ex_is_load_i;
    logic [31:0] if_pc_i, inst_rdata_i, wb_wdata_i;
    logic [4:0]  wb_waddr_i, ex_waddr_i;
    logic [31:0] id_pc_o, rdata1_o, rdata2_o, br_target_o;
    instr_word_u id_inst_o;
    alu_op_t     alu_op_o;
    src1_sel_t   src1_sel_o;
    src2_sel_t   src2_sel_o;
    logic id_valid_o, mem_en_o, mem_we_o, rf_we_o, rf_res_sel_o, br_taken_o, stall_req_o;
    logic [4:0]  rf_waddr_o;

    logic [31:0] model [32];
    logic [31:0] lcg_state = 32'd92;
    logic [31:0] exp_inst, exp_pc, next_pc;
    logic        exp_valid = 1'b0;
    logic        checking = 1'b0;
    int          error_count = 0;

    id_stage u_id_stage (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (wb_we_i && wb_waddr_i != 5'd0) begin
            model[wb_waddr_i] <= wb_wdata_i;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // register value as decode sees it with write-through
    function automatic logic [31:0] exp_reg(input logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (wb_we_i && wb_waddr_i == a) return wb_wdata_i;
        return model[a];
    endfunction

    function automatic exp_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
        exp_t        e;
        logic [5:0]  op, fn;
        logic [4:0]  rs, rt, rd, sh;
        logic [31:0] a, b, pc4, boff;
        int          dst;
        int          br;
        logic        cond, link;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        fn = w[5:0];
        a = exp_reg(rs);
        b = exp_reg(rt);
        pc4 = pc + 32'd4;
        boff = {{14{w[15]}}, w[15:0], 2'b00};
        e = '0;
        dst = 0;
        br = 0;
        cond = 1'b0;
        link = 1'b0;
        case (op)
            op_special: begin
                if (sh == 0 && fn inside {fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
                        fn_and, fn_or, fn_xor, fn_nor, fn_sllv, fn_srlv, fn_srav}) begin
                    e.s1 = 3'b001;
                    e.s2 = 4'b0001;
                    dst = 1;
                end else if (rs == 0 && fn inside {fn_sll, fn_srl, fn_sra}) begin
                    e.s1 = 3'b100;
                    e.s2 = 4'b0001;
                    dst = 1;
                end else if (sh == 0 && rt == 0 && rd == 0 && fn == fn_jr) begin
                    br = 3;
                end else if (sh == 0 && rt == 0 && fn == fn_jalr) begin
                    br = 3;
                    link = 1'b1;
                    dst = 1;
                end
                if (dst == 1 && !link) begin
                    case (fn)
                        fn_add, fn_addu: e.alu = 12'h800;
                        fn_sub, fn_subu: e.alu = 12'h400;
                        fn_slt:          e.alu = 12'h200;
                        fn_sltu:         e.alu = 12'h100;
                        fn_and:          e.alu = 12'h080;
                        fn_nor:          e.alu = 12'h040;
                        fn_or:           e.alu = 12'h020;
                        fn_xor:          e.alu = 12'h010;
                        fn_sll, fn_sllv: e.alu = 12'h008;
                        fn_srl, fn_srlv: e.alu = 12'h004;
                        default:         e.alu = 12'h002;
                    endcase
                end
            end
            op_addi, op_addiu, op_slti, op_sltiu, op_lw, op_sw: begin
                e.alu = (op == op_slti) ? 12'h200 : (op == op_sltiu) ? 12'h100 : 12'h800;
                e.s1 = 3'b001;
                e.s2 = 4'b0010;
                dst = (op == op_sw) ? 0 : 2;
                e.mem_en = (op == op_lw || op == op_sw);
                e.mem_we = (op == op_sw);
                e.res_sel = (op == op_lw);
            end
            op_andi, op_ori, op_xori: begin
                e.alu = (op == op_andi) ? 12'h080 : (op == op_ori) ? 12'h020 : 12'h010;
                e.s1 = 3'b001;
                e.s2 = 4'b1000;
                dst = 2;
            end
            op_lui: begin
                if (rs == 0) begin
                    e.alu = 12'h001;
                    e.s2 = 4'b0010;
                    dst = 2;
                end
            end
            op_beq: begin
                br = 1;
                cond = (a == b);
            end
            op_bne: begin
                br = 1;
                cond = (a != b);
            end
            op_blez: if (rt == 0) begin
                br = 1;
                cond = a[31] || a == 0;
            end
            op_bgtz: if (rt == 0) begin
                br = 1;
                cond = !a[31] && a != 0;
            end
            op_regimm: begin
                if (rt inside {rt_bltz, rt_bltzal}) begin
                    br = 1;
                    cond = a[31];
                end
                if (rt inside {rt_bgez, rt_bgezal}) begin
                    br = 1;
                    cond = !a[31];
                end
                if (rt inside {rt_bltzal, rt_bgezal}) begin
                    link = 1'b1;
                    dst = 3;
                end
            end
            op_j: br = 2;
            op_jal: begin
                br = 2;
                link = 1'b1;
                dst = 3;
            end
            default: e = '0;
        endcase
        // link forms compute pc + 8
        if (link) begin
            e.alu = 12'h800;
            e.s1 = 3'b010;
            e.s2 = 4'b0100;
        end
        e.rf_we = (dst != 0);
        e.waddr = (dst == 1) ? rd : (dst == 2) ? rt : (dst == 3) ? 5'd31 : 5'd0;
        e.target = (br == 1) ? pc4 + boff : (br == 2) ? {pc4[31:28], w[25:0], 2'b00} :
                   (br == 3) ? a : 32'd0;
        e.taken = (br == 1) ? cond : (br != 0);
        return e;
    endfunction

    task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
        if (act !== exp) begin
            error_count++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, act, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] gen_instr();
        logic [31:0] r, s;
        logic [4:0]  rs, rt, rd, sh;
        logic [5:0]  op, fn;
        r = lcg_next();
        s = lcg_next();
        rs = {2'b00, r[2:0]};
        rt = {2'b00, r[5:3]};
        rd = r[10:6];
        sh = r[15:11];
        fn = r_fns[r[23:20]];
        op = i_ops[r[22:20]];
        if (r[19:16] <= 4'd3) begin
            if (fn inside {fn_sll, fn_srl, fn_sra}) rs = 5'd0;
            else sh = 5'd0;
            return {op_special, rs, rt, rd, sh, fn};
        end
        if (r[19:16] <= 4'd6) begin
            if (op == op_lui) rs = 5'd0;
            return {op, rs, rt, s[15:0]};
        end
        if (r[19:16] <= 4'd8) return {r[16] ? op_lw : op_sw, rs, rt, s[15:0]};
        if (r[19:16] == 4'd15) return s;
        case (r[23:20])
            4'd1:    return {op_bne, rs, rt, s[15:0]};
            4'd2:    return {op_blez, rs, 5'd0, s[15:0]};
            4'd3:    return {op_bgtz, rs, 5'd0, s[15:0]};
            4'd4:    return {op_regimm, rs, rt_bltz, s[15:0]};
            4'd5:    return {op_regimm, rs, rt_bgez, s[15:0]};
            4'd6:    return {op_regimm, rs, rt_bltzal, s[15:0]};
            4'd7:    return {op_regimm, rs, rt_bgezal, s[15:0]};
            4'd8:    return {op_j, s[25:0]};
            4'd9:    return {op_jal, s[25:0]};
            4'd10:   return {op_special, rs, 15'd0, fn_jr};
            4'd11:   return {op_special, rs, 5'd0, rd, 5'd0, fn_jalr};
            default: return {op_beq, rs, rt, s[15:0]};
        endcase
    endfunction

    task automatic drive_side();
        logic [31:0] r;
        r = lcg_next();
        wb_we_i = r[0];
        wb_waddr_i = {2'b00, r[3:1]};
        wb_wdata_i = lcg_next();
        ex_is_load_i = r[4];
        ex_waddr_i = {2'b00, r[7:5]};
    endtask

    // offer a pc, wait until decode holds it, then present the word
    task automatic issue(input logic [31:0] w);
        int n;
        n = 0;
        if_pc_i = next_pc;
        if_valid_i = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 8) timed_out("the fetched pc to reach decode");
        end while (!(id_valid_o && id_pc_o == next_pc));
        inst_rdata_i = w;
        exp_inst = w;
        exp_pc = next_pc;
        exp_valid = 1'b1;
        drive_side();
        next_pc = lcg_next() & 32'hffff_fffc;
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (checking) begin
            check_eq(64'(id_valid_o), 64'(exp_valid), "id_valid_o");
            if (id_valid_o) begin
                e = ref_decode(exp_inst, exp_pc);
                check_eq(64'(id_pc_o), 64'(exp_pc), "id_pc_o");
                check_eq(64'(id_inst_o), 64'(exp_inst), "id_inst_o");
                check_eq(64'(alu_op_o), 64'(e.alu), "alu_op_o");
                check_eq(64'(src1_sel_o), 64'(e.s1), "src1_sel_o");
                check_eq(64'(src2_sel_o), 64'(e.s2), "src2_sel_o");
                check_eq(64'({mem_en_o, mem_we_o}), 64'({e.mem_en, e.mem_we}), "mem_en/we");
                check_eq(64'(rf_we_o), 64'(e.rf_we), "rf_we_o");
                check_eq(64'(rf_waddr_o), 64'(e.waddr), "rf_waddr_o");
                check_eq(64'(rf_res_sel_o), 64'(e.res_sel), "rf_res_sel_o");
                check_eq(64'(rdata1_o), 64'(exp_reg(exp_inst[25:21])), "rdata1_o");
                check_eq(64'(rdata2_o), 64'(exp_reg(exp_inst[20:16])), "rdata2_o");
                check_eq(64'(br_taken_o), 64'(e.taken), "br_taken_o");
                check_eq(64'(br_target_o), 64'(e.target), "br_target_o");
                check_eq(64'(stall_req_o), 64'(ex_is_load_i && ex_waddr_i != 0
                    && (ex_waddr_i == exp_inst[25:21] || ex_waddr_i == exp_inst[20:16])),
                    "stall_req_o");
            end
        end
    end

    initial begin
        #2ms;
        $display("simulation ran past its time limit");
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        {if_valid_i, id_stall_i, ex_stall_i, wb_we_i, ex_is_load_i} = '0;
        {if_pc_i, inst_rdata_i, wb_wdata_i, wb_waddr_i, ex_waddr_i} = '0;
        next_pc = 32'h0040_0000;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        checking = 1'b1;
        check_eq(64'({rf_we_o, mem_en_o, br_taken_o, stall_req_o}), 64'd0, "controls after reset");
        for (int r = 1; r < 32; r++) begin
            wb_we_i = 1'b1;
            wb_waddr_i = 5'(r);
            wb_wdata_i = lcg_next();
            @(posedge clk);
            #1;
        end
        wb_we_i = 1'b0;
        for (int i = 0; i < 240; i++) begin
            issue(gen_instr());
            if (i % 20 == 10) begin
                // held stall while memory data keeps changing
                id_stall_i = 1'b1;
                ex_stall_i = 1'b1;
                repeat (2) begin
                    @(posedge clk);
                    #1;
                    inst_rdata_i = lcg_next();
                    drive_side();
                end
                id_stall_i = 1'b0;
                ex_stall_i = 1'b0;
            end else if (i % 20 == 15) begin
                id_stall_i = 1'b1;
                @(posedge clk);
                #1;
                exp_valid = 1'b0;
                inst_rdata_i = lcg_next();
                id_stall_i = 1'b0;
            end
        end
        if_valid_i = 1'b0;
        @(posedge clk);
        #1;
        exp_valid = 1'b0;
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/mips_id_pkg.sv
design/id_input_reg.sv
decode/id_decoder.sv
design/id_regfile.sv
design/id_branch_unit.sv
design/id_stage.sv
testbench/id_stage_properties.sv
testbench/tb_id_stage.sv
